// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_decode_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status.
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/bundle_loader.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module bundle_loader (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      src_cyc,
    input  logic                                      src_stb,
    input  logic                                      src_we,
    input  logic [`DEC_WORD_BITS-1:0]                 src_dat,
    output logic                                      src_ack,
    input  logic                                      drain_done,
    output logic [`DEC_LANES-1:0][`DEC_WORD_BITS-1:0] insn_words,
    output logic                                      bundle_issue
);

    logic [`DEC_LANE_BITS-1:0] fill;
    logic                      holding;
    logic                      accept;
    logic                      last_ack;

    // a fresh transfer, not the one being acked right now.
    assign accept = src_cyc && src_stb && src_we && !src_ack && !holding;

    // fill has already wrapped when the fourth ack is out.
    assign last_ack = src_ack && (fill == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src_ack      <= 1'b0;
            fill         <= '0;
            holding      <= 1'b0;
            bundle_issue <= 1'b0;
        end else begin
            src_ack      <= accept;
            bundle_issue <= last_ack;
            if (accept) begin
                fill <= fill + 1'b1;
            end
            if (last_ack) begin
                holding <= 1'b1;   // back-pressure until drained.
            end else if (drain_done) begin
                holding <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            insn_words[fill] <= src_dat;
        end
    end

    // host only ever writes to this port.
    assert property (@(posedge clk) disable iff (!arst_n)
        src_cyc && src_stb |-> src_we);

endmodule

// ==== hdl/decode_lane.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_lane (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`DEC_WORD_BITS-1:0]   insn,
    input  logic                        bundle_issue,
    output decode_pkg::dec_record_t     record
);

    localparam decode_pkg::dec_record_t ri_record = decode_pkg::dec_record_t'(1);

    logic [5:0]              opcode;
    logic [5:0]              funct;
    decode_pkg::reg_addr_t   rs;
    decode_pkg::reg_addr_t   rt;
    decode_pkg::reg_addr_t   rd;
    decode_pkg::dec_record_t dec;

    assign opcode = insn[31:26];
    assign funct  = insn[5:0];
    assign rs     = insn[25:21];
    assign rt     = insn[20:16];
    assign rd     = insn[15:11];

    always_comb begin
        dec = '0;
        case (opcode)
            `OP_SPECIAL: begin
                dec.regwrite = 1'b1;
                dec.srcrega  = rs;
                dec.srcregb  = rt;
                dec.destreg  = rd;
                case (funct)
                    `FN_ADD:  dec.alu_func = decode_pkg::ALU_ADD;
                    `FN_ADDU: dec.alu_func = decode_pkg::ALU_ADDU;
                    `FN_SUB:  dec.alu_func = decode_pkg::ALU_SUB;
                    `FN_SUBU: dec.alu_func = decode_pkg::ALU_SUBU;
                    `FN_SLT:  dec.alu_func = decode_pkg::ALU_SLT;
                    `FN_SLTU: dec.alu_func = decode_pkg::ALU_SLTU;
                    `FN_AND:  dec.alu_func = decode_pkg::ALU_AND;
                    `FN_OR:   dec.alu_func = decode_pkg::ALU_OR;
                    `FN_XOR:  dec.alu_func = decode_pkg::ALU_XOR;
                    `FN_NOR:  dec.alu_func = decode_pkg::ALU_NOR;
                    `FN_SLLV: dec.alu_func = decode_pkg::ALU_SLL;
                    `FN_SRLV: dec.alu_func = decode_pkg::ALU_SRL;
                    `FN_SRAV: dec.alu_func = decode_pkg::ALU_SRA;
                    `FN_SLL, `FN_SRL, `FN_SRA: begin
                        if (funct == `FN_SLL) begin
                            dec.alu_func = decode_pkg::ALU_SLL;
                        end else if (funct == `FN_SRL) begin
                            dec.alu_func = decode_pkg::ALU_SRL;
                        end else begin
                            dec.alu_func = decode_pkg::ALU_SRA;
                        end
                        dec.shamt_valid = 1'b1;
                        dec.srcrega     = '0;   // rs field unused here.
                    end
                    `FN_JR, `FN_JALR: begin
                        dec.alu_func = decode_pkg::ALU_PASSA;
                        dec.jump     = 1'b1;
                        dec.jr       = 1'b1;
                        dec.srcregb  = '0;
                        dec.regwrite = (funct == `FN_JALR);
                        dec.is_link  = (funct == `FN_JALR);
                        dec.destreg  = (funct == `FN_JALR) ? `DEC_LINK_REG : 5'd0;
                    end
                    default: dec = ri_record;
                endcase
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                dec.regwrite   = 1'b1;
                dec.alusrc_imm = 1'b1;
                dec.srcrega    = rs;
                dec.destreg    = rt;
                case (opcode)
                    `OP_ADDI:  dec.alu_func = decode_pkg::ALU_ADD;
                    `OP_ADDIU: dec.alu_func = decode_pkg::ALU_ADDU;
                    `OP_SLTI:  dec.alu_func = decode_pkg::ALU_SLT;
                    `OP_SLTIU: dec.alu_func = decode_pkg::ALU_SLTU;
                    `OP_ANDI: begin
                        dec.alu_func = decode_pkg::ALU_AND;
                        dec.zeroext  = 1'b1;
                    end
                    `OP_ORI: begin
                        dec.alu_func = decode_pkg::ALU_OR;
                        dec.zeroext  = 1'b1;
                    end
                    `OP_XORI: begin
                        dec.alu_func = decode_pkg::ALU_XOR;
                        dec.zeroext  = 1'b1;
                    end
                    `OP_LUI: begin
                        dec.alu_func = decode_pkg::ALU_LUI;
                        dec.srcrega  = '0;
                    end
                endcase
            end
            `OP_BEQ, `OP_BNE: begin
                dec.branch_type = (opcode == `OP_BEQ) ? decode_pkg::BR_BEQ : decode_pkg::BR_BNE;
                dec.srcrega     = rs;
                dec.srcregb     = rt;
            end
            `OP_BLEZ, `OP_BGTZ: begin
                dec.branch_type = (opcode == `OP_BLEZ) ? decode_pkg::BR_BLEZ : decode_pkg::BR_BGTZ;
                dec.srcrega     = rs;
            end
            `OP_REGIMM: begin
                dec.srcrega = rs;
                case (rt)
                    `RT_BLTZ: dec.branch_type = decode_pkg::BR_BLTZ;
                    `RT_BGEZ: dec.branch_type = decode_pkg::BR_BGEZ;
                    `RT_BLTZAL, `RT_BGEZAL: begin
                        dec.branch_type = (rt == `RT_BLTZAL) ? decode_pkg::BR_BLTZ
                                                             : decode_pkg::BR_BGEZ;
                        dec.regwrite    = 1'b1;
                        dec.is_link     = 1'b1;
                        dec.destreg     = `DEC_LINK_REG;
                    end
                    default: dec = ri_record;
                endcase
            end
            `OP_J: dec.jump = 1'b1;
            `OP_JAL: begin
                dec.jump     = 1'b1;
                dec.regwrite = 1'b1;
                dec.is_link  = 1'b1;
                dec.destreg  = `DEC_LINK_REG;
            end
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
                dec.regwrite   = 1'b1;
                dec.memtoreg   = 1'b1;
                dec.alusrc_imm = 1'b1;
                dec.srcrega    = rs;
                dec.destreg    = rt;
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                dec.memwrite   = 1'b1;
                dec.alusrc_imm = 1'b1;
                dec.srcrega    = rs;
                dec.srcregb    = rt;
            end
            default: dec = ri_record;   // dropped and unknown opcodes.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            record <= '0;
        end else if (bundle_issue) begin
            record <= dec;
        end
    end

    // a reserved word lands in the record as the exception bit alone.
    assert property (@(posedge clk) disable iff (!arst_n)
        bundle_issue && dec.exception_ri |=> record == ri_record);

endmodule

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASSA
    } alu_func_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLEZ,
        BR_BGTZ,
        BR_BLTZ,
        BR_BGEZ
    } branch_t;

    // one lane's decode, exactly one bus word.
    typedef struct packed {
        alu_func_t alu_func;
        branch_t   branch_type;
        logic      regwrite;
        logic      memtoreg;
        logic      memwrite;
        logic      alusrc_imm;
        logic      zeroext;
        logic      shamt_valid;   // shift amount from insn[10:6].
        logic      jump;
        logic      jr;
        logic      is_link;
        reg_addr_t srcrega;
        reg_addr_t srcregb;
        reg_addr_t destreg;
        logic      exception_ri;
    } dec_record_t;

endpackage

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_unit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       src_cyc,
    input  logic                       src_stb,
    input  logic                       src_we,
    input  logic [`DEC_WORD_BITS-1:0]  src_dat,
    output logic                       src_ack,
    output logic                       snk_cyc,
    output logic                       snk_stb,
    output logic                       snk_we,
    output logic [`DEC_ADR_BITS-1:0]   snk_adr,
    output logic [`DEC_WORD_BITS-1:0]  snk_dat,
    input  logic                       snk_ack
);

    logic [`DEC_LANES-1:0][`DEC_WORD_BITS-1:0] insn_words;
    decode_pkg::dec_record_t [`DEC_LANES-1:0]   records;
    logic                                       bundle_issue;
    logic                                       drain_done;

    bundle_loader u_loader (
        .clk          (clk),
        .arst_n       (arst_n),
        .src_cyc      (src_cyc),
        .src_stb      (src_stb),
        .src_we       (src_we),
        .src_dat      (src_dat),
        .src_ack      (src_ack),
        .drain_done   (drain_done),
        .insn_words   (insn_words),
        .bundle_issue (bundle_issue)
    );

    for (genvar i = 0; i < `DEC_LANES; i++) begin : g_lane
        decode_lane u_lane (
            .clk          (clk),
            .arst_n       (arst_n),
            .insn         (insn_words[i]),
            .bundle_issue (bundle_issue),
            .record       (records[i])
        );
    end

    record_writer u_writer (
        .clk          (clk),
        .arst_n       (arst_n),
        .bundle_issue (bundle_issue),
        .records      (records),
        .snk_cyc      (snk_cyc),
        .snk_stb      (snk_stb),
        .snk_we       (snk_we),
        .snk_adr      (snk_adr),
        .snk_dat      (snk_dat),
        .snk_ack      (snk_ack),
        .drain_done   (drain_done)
    );

endmodule

// ==== hdl/record_writer.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module record_writer (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    bundle_issue,
    input  decode_pkg::dec_record_t [`DEC_LANES-1:0] records,
    output logic                                    snk_cyc,
    output logic                                    snk_stb,
    output logic                                    snk_we,
    output logic [`DEC_ADR_BITS-1:0]                snk_adr,
    output logic [`DEC_WORD_BITS-1:0]               snk_dat,
    input  logic                                    snk_ack,
    output logic                                    drain_done
);

    logic                      start;
    logic [`DEC_LANE_BITS-1:0] lane;
    logic [`DEC_SEQ_BITS-1:0]  seq;
    logic                      last_lane;

    assign last_lane = (lane == `DEC_LANE_BITS'(`DEC_LANES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start      <= 1'b0;
            snk_cyc    <= 1'b0;
            snk_stb    <= 1'b0;
            lane       <= '0;
            seq        <= '0;
            drain_done <= 1'b0;
        end else begin
            start      <= bundle_issue;   // lane records settle first.
            drain_done <= 1'b0;
            if (start) begin
                snk_cyc <= 1'b1;
                snk_stb <= 1'b1;
                lane    <= '0;
            end else if (snk_stb && snk_ack) begin
                if (last_lane) begin
                    snk_cyc    <= 1'b0;
                    snk_stb    <= 1'b0;
                    drain_done <= 1'b1;
                    seq        <= seq + 1'b1;   // wraps at 256.
                end
                lane <= lane + 1'b1;
            end
        end
    end

    assign snk_we  = snk_cyc;   // write only master.
    assign snk_adr = {seq, lane};
    assign snk_dat = records[lane];

    // sink wait states must not see the request move.
    assert property (@(posedge clk) disable iff (!arst_n)
        snk_stb && !snk_ack |=> snk_stb && $stable(snk_adr) && $stable(snk_dat));

endmodule

// ==== include/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// lane and bus geometry.
`define DEC_LANES     4
`define DEC_LANE_BITS 2
`define DEC_SEQ_BITS  8
`define DEC_WORD_BITS 32
`define DEC_ADR_BITS  (`DEC_SEQ_BITS + `DEC_LANE_BITS)

`define DEC_LINK_REG  5'd31   // ra, target of the link forms.

// primary opcodes, insn[31:26].
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// SPECIAL funct codes, insn[5:0].
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_JR   6'b001000
`define FN_JALR 6'b001001
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

// REGIMM rt codes, insn[20:16].
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`endif

// ==== include/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// expected decode record for one instruction word.
function automatic logic [31:0] expected_record(input logic [31:0] insn);
    decode_pkg::dec_record_t r;
    decode_pkg::alu_func_t   alu;
    decode_pkg::branch_t     br;
    logic                    zext;
    int                      cls;   // 0 means reserved.
    alu  = decode_pkg::ALU_NONE;
    br   = decode_pkg::BR_NONE;
    zext = 1'b0;
    cls  = 0;
    case (insn[31:26])
        `OP_SPECIAL: begin
            cls = 1;
            case (insn[5:0])
                `FN_ADD:  alu = decode_pkg::ALU_ADD;
                `FN_ADDU: alu = decode_pkg::ALU_ADDU;
                `FN_SUB:  alu = decode_pkg::ALU_SUB;
                `FN_SUBU: alu = decode_pkg::ALU_SUBU;
                `FN_SLT:  alu = decode_pkg::ALU_SLT;
                `FN_SLTU: alu = decode_pkg::ALU_SLTU;
                `FN_AND:  alu = decode_pkg::ALU_AND;
                `FN_OR:   alu = decode_pkg::ALU_OR;
                `FN_XOR:  alu = decode_pkg::ALU_XOR;
                `FN_NOR:  alu = decode_pkg::ALU_NOR;
                `FN_SLLV: alu = decode_pkg::ALU_SLL;
                `FN_SRLV: alu = decode_pkg::ALU_SRL;
                `FN_SRAV: alu = decode_pkg::ALU_SRA;
                `FN_SLL: begin
                    alu = decode_pkg::ALU_SLL;
                    cls = 2;
                end
                `FN_SRL: begin
                    alu = decode_pkg::ALU_SRL;
                    cls = 2;
                end
                `FN_SRA: begin
                    alu = decode_pkg::ALU_SRA;
                    cls = 2;
                end
                `FN_JR:   cls = 3;
                `FN_JALR: cls = 4;
                default:  cls = 0;
            endcase
        end
        `OP_ADDI:  begin cls = 5; alu = decode_pkg::ALU_ADD;  end
        `OP_ADDIU: begin cls = 5; alu = decode_pkg::ALU_ADDU; end
        `OP_SLTI:  begin cls = 5; alu = decode_pkg::ALU_SLT;  end
        `OP_SLTIU: begin cls = 5; alu = decode_pkg::ALU_SLTU; end
        `OP_ANDI:  begin cls = 5; alu = decode_pkg::ALU_AND; zext = 1'b1; end
        `OP_ORI:   begin cls = 5; alu = decode_pkg::ALU_OR;  zext = 1'b1; end
        `OP_XORI:  begin cls = 5; alu = decode_pkg::ALU_XOR; zext = 1'b1; end
        `OP_LUI:   begin cls = 5; alu = decode_pkg::ALU_LUI;  end
        `OP_BEQ:   begin cls = 6; br = decode_pkg::BR_BEQ;  end
        `OP_BNE:   begin cls = 6; br = decode_pkg::BR_BNE;  end
        `OP_BLEZ:  begin cls = 7; br = decode_pkg::BR_BLEZ; end
        `OP_BGTZ:  begin cls = 7; br = decode_pkg::BR_BGTZ; end
        `OP_REGIMM: begin
            case (insn[20:16])
                `RT_BLTZ:   begin cls = 7; br = decode_pkg::BR_BLTZ; end
                `RT_BGEZ:   begin cls = 7; br = decode_pkg::BR_BGEZ; end
                `RT_BLTZAL: begin cls = 8; br = decode_pkg::BR_BLTZ; end
                `RT_BGEZAL: begin cls = 8; br = decode_pkg::BR_BGEZ; end
                default:    cls = 0;
            endcase
        end
        `OP_J:   cls = 9;
        `OP_JAL: cls = 10;
        `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: cls = 11;
        `OP_SB, `OP_SH, `OP_SW: cls = 12;
        default: cls = 0;
    endcase
    r = '0;
    r.alu_func    = alu;
    r.branch_type = br;
    r.zeroext     = zext;
    case (cls)
        1:  begin r.regwrite = 1'b1; r.srcrega = insn[25:21]; end
        2:  begin r.regwrite = 1'b1; r.shamt_valid = 1'b1; end
        3, 4: begin
            r.alu_func = decode_pkg::ALU_PASSA;
            r.jump     = 1'b1;
            r.jr       = 1'b1;
            r.srcrega  = insn[25:21];
        end
        5: begin
            r.regwrite   = 1'b1;
            r.alusrc_imm = 1'b1;
            r.srcrega    = (alu == decode_pkg::ALU_LUI) ? 5'd0 : insn[25:21];
            r.destreg    = insn[20:16];
        end
        6, 7, 8: r.srcrega = insn[25:21];
        9, 10: r.jump = 1'b1;
        11: begin
            r.regwrite   = 1'b1;
            r.memtoreg   = 1'b1;
            r.alusrc_imm = 1'b1;
            r.srcrega    = insn[25:21];
            r.destreg    = insn[20:16];
        end
        12: begin
            r.memwrite   = 1'b1;
            r.alusrc_imm = 1'b1;
            r.srcrega    = insn[25:21];
            r.srcregb    = insn[20:16];
        end
        default: begin
            r              = '0;
            r.exception_ri = 1'b1;
        end
    endcase
    if (cls == 1 || cls == 2) begin
        r.srcregb = insn[20:16];
        r.destreg = insn[15:11];
    end
    if (cls == 6) begin
        r.srcregb = insn[20:16];
    end
    if (cls == 4 || cls == 8 || cls == 10) begin
        r.regwrite = 1'b1;   // link forms write ra.
        r.is_link  = 1'b1;
        r.destreg  = `DEC_LINK_REG;
    end
    return r;
endfunction

`endif

// ==== sim/tb_decode_unit.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_decode_unit;

    localparam int CLK_PERIOD        = 40;
    localparam int CYCLES_PER_BUNDLE = 200;
    localparam int N_BUNDLES         = 1 + 8 + 4 + 3 + 4 + 300;

    logic                        clk;
    logic                        arst_n;
    logic                        src_cyc;
    logic                        src_stb;
    logic                        src_we;
    logic [`DEC_WORD_BITS-1:0]   src_dat;
    logic                        src_ack;
    logic                        snk_cyc;
    logic                        snk_stb;
    logic                        snk_we;
    logic [`DEC_ADR_BITS-1:0]    snk_adr;
    logic [`DEC_WORD_BITS-1:0]   snk_dat;
    logic                        snk_ack;

    integer                      seed = 32'h4e72;
    integer                      stim_seed = 32'h4e72;
    logic [1:0]                  wait_left = 2'd0;
    logic [`DEC_SEQ_BITS-1:0]    exp_seq = '0;
    logic [`DEC_ADR_BITS-1:0]    rx_adr [$];
    logic [`DEC_WORD_BITS-1:0]   rx_dat [$];
    int                          src_acks = 0;
    logic                        draining = 1'b0;
    string                       test_name = "reset";

    `include "tb_decode_model.svh"

    decode_unit i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .src_cyc (src_cyc),
        .src_stb (src_stb),
        .src_we  (src_we),
        .src_dat (src_dat),
        .src_ack (src_ack),
        .snk_cyc (snk_cyc),
        .snk_stb (snk_stb),
        .snk_we  (snk_we),
        .snk_adr (snk_adr),
        .snk_dat (snk_dat),
        .snk_ack (snk_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {`OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // sink slave, 0 to 3 wait states per write.
    always @(posedge clk) begin
        if (snk_ack) begin
            snk_ack <= 1'b0;
        end else if (snk_stb) begin
            if (wait_left == 2'd0) begin
                snk_ack   <= 1'b1;
                wait_left <= 2'($random(seed));
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // sink capture and source ack monitor.
    always @(posedge clk) begin
        if (arst_n) begin
            if (snk_stb && snk_ack) begin
                check_value({test_name, " sink cyc"}, 32'd1, 32'(snk_cyc));
                check_value({test_name, " sink we"}, 32'd1, 32'(snk_we));
                rx_adr.push_back(snk_adr);
                rx_dat.push_back(snk_dat);
                if (snk_adr[1:0] == 2'd3) begin
                    draining = 1'b0;
                end
            end
            if (src_ack) begin
                if (draining) begin
                    stop_on_error("source write was acked while a bundle was still draining");
                end
                src_acks = src_acks + 1;
                if (src_acks == `DEC_LANES) begin
                    draining = 1'b1;
                    src_acks = 0;
                end
            end
        end
    end

    task automatic send_word(input logic [31:0] word);
        src_cyc <= 1'b1;
        src_stb <= 1'b1;
        src_we  <= 1'b1;
        src_dat <= word;
        @(posedge clk);
        while (!src_ack) begin
            @(posedge clk);
        end
    endtask

    // source writes and sink checks run side by side.
    task automatic run_words(input logic [31:0] words [$]);
        fork
            begin
                @(posedge clk);
                foreach (words[i]) begin
                    send_word(words[i]);
                end
                src_cyc <= 1'b0;
                src_stb <= 1'b0;
                src_we  <= 1'b0;
            end
            begin
                foreach (words[i]) begin
                    while (rx_dat.size() == 0) begin
                        @(negedge clk);
                    end
                    check_value({test_name, " address"}, 32'({exp_seq, 2'(i)}),
                                32'(rx_adr.pop_front()));
                    check_value({test_name, " record"}, expected_record(words[i]),
                                rx_dat.pop_front());
                    if (i % `DEC_LANES == `DEC_LANES - 1) begin
                        exp_seq = exp_seq + 1'b1;
                    end
                end
            end
        join
    endtask

    task automatic test_reset_state();
        logic [31:0] words [$];
        test_name = "reset_state";
        repeat (10) begin
            @(posedge clk);
            check_value(test_name, 32'd0, 32'({src_ack, snk_cyc, snk_stb}));
        end
        arst_n <= 1'b1;
        @(posedge clk);
        check_value(test_name, 32'd0, 32'({src_ack, snk_cyc, snk_stb}));
        words = '{encode_r(`FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0), encode_i(`OP_LW, 5'd29, 5'd8, 16'h0010),
                  encode_i(`OP_BEQ, 5'd4, 5'd5, 16'hfffc), {`OP_J, 26'h0123456}};
        run_words(words);
    endtask

    task automatic test_rtype_shift();
        logic [5:0]  fns [$];
        logic [31:0] words [$];
        test_name = "rtype_shift";
        fns = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU, `FN_AND, `FN_OR,
                `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV};
        for (int k = 0; k < 2; k++) begin
            foreach (fns[i]) begin
                words.push_back(encode_r(fns[i], 5'(i + k * 7), 5'(i * 3 + k), 5'(31 - i - k),
                                         5'(i + 1)));
            end
        end
        run_words(words);
    endtask

    task automatic test_imm_mem();
        logic [5:0]  ops [$];
        logic [31:0] words [$];
        test_name = "imm_load_store";
        ops = '{`OP_LUI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW};
        foreach (ops[i]) begin
            words.push_back(encode_i(ops[i], 5'(i + 2), 5'(20 - i), 16'(i * 16'h1111)));
        end
        run_words(words);
    endtask

    task automatic test_branch_jump();
        logic [31:0] words [$];
        test_name = "branch_jump";
        words = '{encode_i(`OP_BEQ, 5'd3, 5'd7, 16'h0004), encode_i(`OP_BNE, 5'd12, 5'd1, 16'h8000),
                  encode_i(`OP_BLEZ, 5'd6, 5'd5, 16'h0020),
                  encode_i(`OP_BGTZ, 5'd30, 5'd17, 16'hff00),
                  encode_i(`OP_REGIMM, 5'd8, `RT_BLTZ, 16'h0001),
                  encode_i(`OP_REGIMM, 5'd9, `RT_BGEZ, 16'h0002),
                  encode_i(`OP_REGIMM, 5'd10, `RT_BLTZAL, 16'h0003),
                  encode_i(`OP_REGIMM, 5'd11, `RT_BGEZAL, 16'h0004),
                  {`OP_J, 26'h3ffffff}, {`OP_JAL, 26'h1af3c40},
                  encode_r(`FN_JR, 5'd31, 5'd6, 5'd9, 5'd3),
                  encode_r(`FN_JALR, 5'd4, 5'd2, 5'd7, 5'd3)};
        run_words(words);
    endtask

    task automatic test_reserved();
        logic [31:0] words [$];
        test_name = "reserved";
        words = '{{6'h1c, 26'h0850002}, {6'h10, 26'h0800000}, {6'h2f, 26'h0a10000},
                  {6'h30, 26'h0430008}, {6'h38, 26'h0430008}, {6'h22, 26'h0220003},
                  {6'h26, 26'h0220003}, {6'h2a, 26'h0220003}, {6'h2e, 26'h0220003},
                  encode_r(6'h18, 5'd2, 5'd3, 5'd0, 5'd0), encode_r(6'h1a, 5'd2, 5'd3, 5'd0, 5'd0),
                  encode_r(6'h10, 5'd0, 5'd0, 5'd4, 5'd0), encode_r(6'h0a, 5'd5, 5'd6, 5'd7, 5'd0),
                  encode_r(6'h0c, 5'd0, 5'd0, 5'd0, 5'd0), encode_r(6'h3f, 5'd1, 5'd1, 5'd1, 5'd1),
                  encode_i(`OP_REGIMM, 5'd3, 5'h02, 16'h0010)};
        run_words(words);
    endtask

    task automatic test_backpressure();
        logic [31:0] words [$];
        logic [31:0] w;
        logic [1:0]  sel;
        test_name = "backpressure";
        for (int n = 0; n < `DEC_LANES * 300; n++) begin
            w   = $random(stim_seed);
            sel = 2'($random(stim_seed));
            case (sel)
                2'd1: w[31:26] = {2'b00, w[29:26]};   // all kept opcodes.
                2'd2: w[31:26] = {2'b10, w[29:26]};   // memory ops, some dropped.
                2'd3: w[31:26] = `OP_SPECIAL;
                default: ;
            endcase
            words.push_back(w);
        end
        run_words(words);
    endtask

    initial begin
        #(CLK_PERIOD * CYCLES_PER_BUNDLE * N_BUNDLES);
        stop_on_error("timeout: the tests did not finish in the allowed time");
    end

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        src_cyc = 1'b0;
        src_stb = 1'b0;
        src_we  = 1'b0;
        src_dat = '0;
        snk_ack = 1'b0;
        test_reset_state();
        test_rtype_shift();
        test_imm_mem();
        test_branch_jump();
        test_reserved();
        test_backpressure();
        repeat (4) @(posedge clk);
        check_value({test_name, " leftover records"}, 32'd0, 32'(rx_dat.size()));
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/decode_pkg.sv
hdl/bundle_loader.sv
hdl/decode_lane.sv
hdl/record_writer.sv
hdl/decode_unit.sv
sim/tb_decode_unit.sv
